/* tb/ex_cases.txt */
# id op(hex) operand_1 operand_2 addr write_en | expected: data write_en overflow
# NOP lines with write_en 0 get random operands
1  10 00000000 00000000 01 1 00000000 1 0
2  12 00000000 00000000 02 1 00000000 1 0
3  00 00000000 00000000 00 0 00000000 0 0
4  25 f0f00000 00000ff0 03 1 f0f00ff0 1 0
5  24 ff00ff00 0f0f0f0f 04 1 0f000f00 1 0
6  27 0000ffff 00ff0000 05 1 ff000000 1 0
7  26 aaaa5555 ffff0000 06 1 55555555 1 0
8  04 00000004 000000ff 07 1 00000ff0 1 0
9  06 0000001f 80000000 08 1 00000001 1 0
10 07 00000008 f0000000 09 1 fff00000 1 0
11 07 00000000 80000001 0a 1 80000001 1 0
12 20 7fffffff 00000001 0b 1 80000000 0 1
13 21 7fffffff 00000001 0c 1 80000000 1 0
14 22 80000000 00000001 0d 1 7fffffff 0 1
15 23 80000000 00000001 0e 1 7fffffff 1 0
16 2a ffffffff 00000001 0f 1 00000001 1 0
17 2b ffffffff 00000001 10 1 00000000 1 0
18 30 00000000 00000000 11 1 00000020 1 0
19 30 00010000 00000000 12 1 0000000f 1 0
20 31 ffffffff 00000000 13 1 00000020 1 0
21 02 fffffffd 00000007 14 1 ffffffeb 1 0
22 18 fffffffe 00000003 15 0 00000000 0 0
23 10 00000000 00000000 16 1 ffffffff 1 0
24 12 00000000 00000000 17 1 fffffffa 1 0
25 19 ffffffff ffffffff 18 0 00000000 0 0
26 10 00000000 00000000 19 1 fffffffe 1 0
27 12 00000000 00000000 1a 1 00000001 1 0
28 11 12345678 00000000 1b 0 00000000 0 0
29 12 00000000 00000000 1c 1 00000001 1 0
30 13 9abcdef0 00000000 1d 0 00000000 0 0
31 10 00000000 00000000 1e 1 12345678 1 0
32 0a cafef00d 00000000 1f 1 cafef00d 1 0
33 0b 0badc0de 00000001 01 1 0badc0de 1 0
34 00 00000000 00000000 00 0 00000000 0 0

/* ex_stage.f */
common/ex_pkg.sv
common/hilo_if.sv
alu/arith_unit.sv
alu/logic_shift_unit.sv
hdl/mul_unit.sv
hdl/hilo_reg.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
tb/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage.f \
    && ./obj_dir/Vex_stage_tb > sim.log 2>&1 \
    || echo "build or simulation run reported an error"

cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* tb/ex_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_CASES    = 64;
    localparam string CASE_FILE    = "tb/ex_cases.txt";

    logic      clk = 1'b0;
    logic      rst_i;
    alu_op_e   alu_op_i;
    word_t     operand_1_i;
    word_t     operand_2_i;
    reg_addr_t reg_write_addr_i;
    logic      reg_write_en_i;
    word_t     reg_write_data_o;
    reg_addr_t reg_write_addr_o;
    logic      reg_write_en_o;
    logic      overflow_o;

    // one entry per data line of the case file
    int        case_id   [MAX_CASES];
    alu_op_e   case_op   [MAX_CASES];
    word_t     case_op1  [MAX_CASES];
    word_t     case_op2  [MAX_CASES];
    reg_addr_t case_addr [MAX_CASES];
    logic      case_wen  [MAX_CASES];
    word_t     exp_data  [MAX_CASES];
    logic      exp_wen   [MAX_CASES];
    logic      exp_ovf   [MAX_CASES];

    int   num_cases    = 0;
    int   error_count  = 0;
    int   passed_count = 0;
    int   failed_count = 0;
    int   cycle_count  = 0;
    int   cycle_limit  = 20;
    int   reset_errors;
    logic file_ok;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ex_stage #(.DATA_W(32)) i_dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .alu_op_i         (alu_op_i),
        .operand_1_i      (operand_1_i),
        .operand_2_i      (operand_2_i),
        .reg_write_addr_i (reg_write_addr_i),
        .reg_write_en_i   (reg_write_en_i),
        .reg_write_data_o (reg_write_data_o),
        .reg_write_addr_o (reg_write_addr_o),
        .reg_write_en_o   (reg_write_en_o),
        .overflow_o       (overflow_o)
    );

    task automatic check_word(input int id, input string what, input word_t expected,
                              input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns test %0d %s: expected %h, got %h",
                     $time, id, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input int id, input string what, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns test %0d %s: expected %b, got %b",
                     $time, id, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_addr(input int id, input string what, input reg_addr_t expected,
                              input reg_addr_t actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns test %0d %s: expected %h, got %h",
                     $time, id, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic read_cases();
        int         fd;
        int         fields;
        string      line;
        int         id;
        logic [5:0] op;
        word_t      op1;
        word_t      op2;
        reg_addr_t  addr;
        logic       wen;
        word_t      data;
        logic       ewen;
        logic       eovf;
        fd = $fopen(CASE_FILE, "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h",
                                 id, op, op1, op2, addr, wen, data, ewen, eovf);
                // comment lines give no fields
                if (fields == 9 && num_cases < MAX_CASES) begin
                    case_id[num_cases]   = id;
                    case_op[num_cases]   = alu_op_e'(op);
                    case_op1[num_cases]  = op1;
                    case_op2[num_cases]  = op2;
                    case_addr[num_cases] = addr;
                    case_wen[num_cases]  = wen;
                    exp_data[num_cases]  = data;
                    exp_wen[num_cases]   = ewen;
                    exp_ovf[num_cases]   = eovf;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = num_cases + 20;
    endtask

    task automatic drive_idle();
        alu_op_i         = OP_NOP;
        operand_1_i      = '0;
        operand_2_i      = '0;
        reg_write_addr_i = '0;
        reg_write_en_i   = 1'b0;
    endtask

    task automatic drive_case(input int idx);
        alu_op_i         = case_op[idx];
        operand_1_i      = case_op1[idx];
        operand_2_i      = case_op2[idx];
        reg_write_addr_i = case_addr[idx];
        reg_write_en_i   = case_wen[idx];
        // operands don't matter for a NOP without write
        if (case_op[idx] == OP_NOP && !case_wen[idx]) begin
            operand_1_i = $urandom();
            operand_2_i = $urandom();
        end
    endtask

    task automatic check_case(input int idx);
        int         errors_before;
        alu_op_e    op_now;
        res_class_e cls;
        errors_before = error_count;
        op_now = case_op[idx];
        cls = op_class(op_now);
        check_word(case_id[idx], "data", exp_data[idx], reg_write_data_o);
        check_addr(case_id[idx], "address", case_addr[idx], reg_write_addr_o);
        check_flag(case_id[idx], "write enable", exp_wen[idx], reg_write_en_o);
        check_flag(case_id[idx], "overflow", exp_ovf[idx], overflow_o);
        if (error_count == errors_before) begin
            passed_count++;
            $display("test %0d %s (%s): ok", case_id[idx], op_now.name(), cls.name());
        end else begin
            failed_count++;
            $display("test %0d %s (%s): mismatch", case_id[idx], op_now.name(), cls.name());
        end
    endtask

    // hung-run guard sized by the case count
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'ha5d));
        rst_i = 1'b1;
        drive_idle();
        read_cases();
        if (!file_ok) begin
            $display("could not open %s, no tests were run", CASE_FILE);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            reset_errors = error_count;
            repeat (RESET_CYCLES) begin
                @(posedge clk);
                #1;
                check_word(0, "reset data", '0, reg_write_data_o);
                check_addr(0, "reset address", '0, reg_write_addr_o);
                check_flag(0, "reset write enable", 1'b0, reg_write_en_o);
                check_flag(0, "reset overflow", 1'b0, overflow_o);
            end
            if (error_count == reset_errors) begin
                passed_count++;
                $display("test 0 reset: ok");
            end else begin
                failed_count++;
                $display("test 0 reset: mismatch");
            end
            rst_i = 1'b0;
            // case i is driven while case i-1 sits on the outputs
            for (int i = 0; i <= num_cases; i++) begin
                if (i < num_cases) begin
                    drive_case(i);
                end else begin
                    drive_idle();
                end
                #(CLK_PERIOD - 2);
                if (i > 0) begin
                    check_case(i - 1);
                end
                @(posedge clk);
                #1;
            end
            $display("%0d tests passed, %0d tests failed", passed_count, failed_count);
            if (error_count == 0 && num_cases > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                if (num_cases == 0) begin
                    $display("no cases found in %s", CASE_FILE);
                end
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage import ex_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic clk,
    input  wire logic rst_i,
    input  alu_op_e   alu_op_i,
    input  word_t     operand_1_i,
    input  word_t     operand_2_i,
    input  reg_addr_t reg_write_addr_i,
    input  wire logic reg_write_en_i,
    output word_t     reg_write_data_o,
    output reg_addr_t reg_write_addr_o,
    output logic      reg_write_en_o,
    output logic      overflow_o
);

    word_t  arith_result;
    logic   arith_overflow;
    word_t  logic_shift_result;
    dword_t product;

    hilo_if #(.DATA_W(DATA_W)) hilo_bus ();

    arith_unit #(.DATA_W(DATA_W)) i_arith_unit (
        .alu_op_i       (alu_op_i),
        .operand_1_i    (operand_1_i),
        .operand_2_i    (operand_2_i),
        .arith_result_o (arith_result),
        .overflow_o     (arith_overflow)
    );

    logic_shift_unit #(.DATA_W(DATA_W)) i_logic_shift_unit (
        .alu_op_i             (alu_op_i),
        .operand_1_i          (operand_1_i),
        .operand_2_i          (operand_2_i),
        .logic_shift_result_o (logic_shift_result)
    );

    mul_unit #(.DATA_W(DATA_W)) i_mul_unit (
        .alu_op_i    (alu_op_i),
        .operand_1_i (operand_1_i),
        .operand_2_i (operand_2_i),
        .product_o   (product)
    );

    hilo_reg #(.DATA_W(DATA_W)) i_hilo_reg (
        .clk   (clk),
        .rst_i (rst_i),
        .hilo  (hilo_bus.owner)
    );

    ex_writeback #(.DATA_W(DATA_W)) i_ex_writeback (
        .clk                  (clk),
        .rst_i                (rst_i),
        .alu_op_i             (alu_op_i),
        .reg_write_addr_i     (reg_write_addr_i),
        .reg_write_en_i       (reg_write_en_i),
        .operand_1_i          (operand_1_i),
        .arith_result_i       (arith_result),
        .overflow_i           (arith_overflow),
        .logic_shift_result_i (logic_shift_result),
        .product_i            (product),
        .hilo                 (hilo_bus.user),
        .reg_write_data_o     (reg_write_data_o),
        .reg_write_addr_o     (reg_write_addr_o),
        .reg_write_en_o       (reg_write_en_o),
        .overflow_o           (overflow_o)
    );

endmodule

`default_nettype wire

/* hdl/ex_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_writeback import ex_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wire logic clk,
    input  wire logic rst_i,
    input  alu_op_e   alu_op_i,
    input  reg_addr_t reg_write_addr_i,
    input  wire logic reg_write_en_i,
    input  word_t     operand_1_i,
    input  word_t     arith_result_i,
    input  wire logic overflow_i,
    input  word_t     logic_shift_result_i,
    input  dword_t    product_i,
    hilo_if.user      hilo,
    output word_t     reg_write_data_o,
    output reg_addr_t reg_write_addr_o,
    output logic      reg_write_en_o,
    output logic      overflow_o
);

    logic [DATA_W-1:0] result_d;
    logic [DATA_W-1:0] move_result;

    always_comb begin
        case (alu_op_i)
            OP_MFHI: move_result = hilo.hi;
            OP_MFLO: move_result = hilo.lo;
            // MOVZ and MOVN pass operand 1 through
            default: move_result = operand_1_i;
        endcase
    end

    always_comb begin
        case (op_class(alu_op_i))
            RES_LOGIC, RES_SHIFT: result_d = logic_shift_result_i;
            RES_ARITH:            result_d = arith_result_i;
            RES_MOVE:             result_d = move_result;
            RES_MUL:              result_d = product_i[DATA_W-1:0];
            default:              result_d = '0;
        endcase
    end

    // overflow cancels the register write
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_write_data_o <= '0;
            reg_write_addr_o <= '0;
            reg_write_en_o   <= 1'b0;
            overflow_o       <= 1'b0;
        end else begin
            reg_write_data_o <= result_d;
            reg_write_addr_o <= reg_write_addr_i;
            reg_write_en_o   <= reg_write_en_i && !overflow_i;
            overflow_o       <= overflow_i;
        end
    end

    // HI/LO requests carry both halves on every write
    always_comb begin
        hilo.write_en = 1'b0;
        hilo.hi_wdata = hilo.hi;
        hilo.lo_wdata = hilo.lo;
        case (alu_op_i)
            OP_MULT, OP_MULTU: begin
                hilo.write_en = 1'b1;
                hilo.hi_wdata = product_i[2*DATA_W-1:DATA_W];
                hilo.lo_wdata = product_i[DATA_W-1:0];
            end
            OP_MTHI: begin
                hilo.write_en = 1'b1;
                hilo.hi_wdata = operand_1_i;
            end
            OP_MTLO: begin
                hilo.write_en = 1'b1;
                hilo.lo_wdata = operand_1_i;
            end
            default: begin
            end
        endcase
    end

    // overflow only follows a signed add or subtract and never comes with a write
    a_no_write_on_overflow: assert property (
        @(posedge clk) disable iff (rst_i)
        overflow_o |-> (!reg_write_en_o &&
                        ($past(alu_op_i) inside {OP_ADD, OP_ADDI, OP_SUB}))
    ) else $error("overflow reported with a write or after a non-signed op");

endmodule

`default_nettype wire

/* hdl/hilo_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module hilo_reg #(
    parameter int DATA_W = 32
) (
    input wire logic clk,
    input wire logic rst_i,
    hilo_if.owner    hilo
);

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;

    // both halves load together
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (hilo.write_en) begin
            hi_q <= hilo.hi_wdata;
            lo_q <= hilo.lo_wdata;
        end
    end

    // read back without delay
    assign hilo.hi = hi_q;
    assign hilo.lo = lo_q;

    // write request comes from the execute side
    a_write_en_known: assert property (
        @(posedge clk) disable iff (rst_i) !$isunknown(hilo.write_en)
    ) else $error("HI/LO write enable unknown");

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_unit import ex_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  alu_op_e alu_op_i,
    input  word_t   operand_1_i,
    input  word_t   operand_2_i,
    output dword_t  product_o
);

    logic                is_signed;
    logic                negate;
    logic [DATA_W-1:0]   mag_1;
    logic [DATA_W-1:0]   mag_2;
    logic [2*DATA_W-1:0] product_mag;

    assign is_signed = (alu_op_i == OP_MUL) || (alu_op_i == OP_MULT);

    // magnitudes for the signed forms
    assign mag_1 = (is_signed && operand_1_i[DATA_W-1]) ? (~operand_1_i + 1'b1) : operand_1_i;
    assign mag_2 = (is_signed && operand_2_i[DATA_W-1]) ? (~operand_2_i + 1'b1) : operand_2_i;

    assign product_mag = {{DATA_W{1'b0}}, mag_1} * {{DATA_W{1'b0}}, mag_2};

    // result is negative when the signs differ
    assign negate = is_signed && (operand_1_i[DATA_W-1] ^ operand_2_i[DATA_W-1]);

    assign product_o = negate ? (~product_mag + 1'b1) : product_mag;

endmodule

`default_nettype wire

/* alu/logic_shift_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module logic_shift_unit import ex_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  alu_op_e alu_op_i,
    input  word_t   operand_1_i,
    input  word_t   operand_2_i,
    output word_t   logic_shift_result_o
);

    localparam int SHAMT_W = $clog2(DATA_W);

    logic [SHAMT_W-1:0]       shamt;
    logic signed [DATA_W-1:0] operand_2_signed;

    // shift amount from the low bits of operand 1
    assign shamt = operand_1_i[SHAMT_W-1:0];
    assign operand_2_signed = operand_2_i;

    always_comb begin
        case (alu_op_i)
            OP_OR:   logic_shift_result_o = operand_1_i | operand_2_i;
            OP_AND:  logic_shift_result_o = operand_1_i & operand_2_i;
            OP_NOR:  logic_shift_result_o = ~(operand_1_i | operand_2_i);
            OP_XOR:  logic_shift_result_o = operand_1_i ^ operand_2_i;
            OP_SLL:  logic_shift_result_o = operand_2_i << shamt;
            OP_SRL:  logic_shift_result_o = operand_2_i >> shamt;
            // sign fill
            OP_SRA:  logic_shift_result_o = operand_2_signed >>> shamt;
            default: logic_shift_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu/arith_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module arith_unit import ex_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  alu_op_e alu_op_i,
    input  word_t   operand_1_i,
    input  word_t   operand_2_i,
    output word_t   arith_result_o,
    output logic    overflow_o
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic                   is_sub;
    logic [DATA_W-1:0]      operand_2_mux;
    logic [DATA_W-1:0]      sum;
    logic                   b_sign;
    logic                   signed_ovf;
    logic                   smaller_signed;
    logic                   smaller_unsigned;
    logic [CNT_W-1:0]       lead_zero;
    logic [CNT_W-1:0]       lead_one;
    logic signed [DATA_W:0] wide_sum;
    logic                   wide_ovf;

    function automatic logic [CNT_W-1:0] count_leading_zeros(input logic [DATA_W-1:0] value);
        logic [CNT_W-1:0] count;
        logic             done;
        count = '0;
        done  = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (!done && !value[i]) begin
                count = count + 1'b1;
            end else begin
                done = 1'b1;
            end
        end
        return count;
    endfunction

    // SLT goes through the subtractor as well
    assign is_sub = (alu_op_i == OP_SUB) || (alu_op_i == OP_SUBU) || (alu_op_i == OP_SLT);
    assign operand_2_mux = is_sub ? (~operand_2_i + 1'b1) : operand_2_i;
    assign sum = operand_1_i + operand_2_mux;

    // sign of the true second operand so that op1 - 0x8000_0000 is caught
    assign b_sign = is_sub ? ~operand_2_i[DATA_W-1] : operand_2_i[DATA_W-1];
    assign signed_ovf = (operand_1_i[DATA_W-1] == b_sign) &&
                        (sum[DATA_W-1] != operand_1_i[DATA_W-1]);

    assign smaller_signed = (operand_1_i[DATA_W-1] && !operand_2_i[DATA_W-1]) ||
                            ((operand_1_i[DATA_W-1] == operand_2_i[DATA_W-1]) && sum[DATA_W-1]);
    assign smaller_unsigned = operand_1_i < operand_2_i;

    assign lead_zero = count_leading_zeros(operand_1_i);
    assign lead_one  = count_leading_zeros(~operand_1_i);

    // one extra bit of range as a second opinion on overflow
    assign wide_sum = (alu_op_i == OP_SUB) ?
                      ($signed({operand_1_i[DATA_W-1], operand_1_i}) -
                       $signed({operand_2_i[DATA_W-1], operand_2_i})) :
                      ($signed({operand_1_i[DATA_W-1], operand_1_i}) +
                       $signed({operand_2_i[DATA_W-1], operand_2_i}));
    assign wide_ovf = wide_sum[DATA_W] != wide_sum[DATA_W-1];

    always_comb begin
        overflow_o = signed_ovf && ((alu_op_i == OP_ADD) || (alu_op_i == OP_ADDI) ||
                                    (alu_op_i == OP_SUB));
        case (alu_op_i)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_SUB, OP_SUBU: arith_result_o = sum;
            OP_SLT:  arith_result_o = {{(DATA_W-1){1'b0}}, smaller_signed};
            OP_SLTU: arith_result_o = {{(DATA_W-1){1'b0}}, smaller_unsigned};
            OP_CLZ:  arith_result_o = {{(DATA_W-CNT_W){1'b0}}, lead_zero};
            OP_CLO:  arith_result_o = {{(DATA_W-CNT_W){1'b0}}, lead_one};
            default: arith_result_o = '0;
        endcase
        // unsigned forms never flag, signed add and subtract follow the wide sum
        if (!$isunknown({alu_op_i, operand_1_i, operand_2_i})) begin
            assert (overflow_o == (wide_ovf && (alu_op_i inside {OP_ADD, OP_ADDI, OP_SUB})))
                else $error("overflow flag wrong for op %s", alu_op_i.name());
        end
    end

endmodule

`default_nettype wire

/* common/hilo_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface hilo_if #(
    parameter int DATA_W = 32
);

    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
    logic              write_en;
    logic [DATA_W-1:0] hi_wdata;
    logic [DATA_W-1:0] lo_wdata;

    // register side
    modport owner (output hi, output lo, input write_en, input hi_wdata, input lo_wdata);

    // execute side, reads current values and requests writes
    modport user (input hi, input lo, output write_en, output hi_wdata, output lo_wdata);

endinterface

`default_nettype wire

/* common/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 2 * WORD_W;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [DWORD_W-1:0]    dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // mostly special/special2 funct codes, shifts use the variable forms
    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_MUL   = 6'h02,
        OP_SLL   = 6'h04,
        OP_SRL   = 6'h06,
        OP_SRA   = 6'h07,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_MOVZ  = 6'h0a,
        OP_MOVN  = 6'h0b,
        OP_MFHI  = 6'h10,
        OP_MTHI  = 6'h11,
        OP_MFLO  = 6'h12,
        OP_MTLO  = 6'h13,
        OP_MULT  = 6'h18,
        OP_MULTU = 6'h19,
        OP_ADD   = 6'h20,
        OP_ADDU  = 6'h21,
        OP_SUB   = 6'h22,
        OP_SUBU  = 6'h23,
        OP_AND   = 6'h24,
        OP_OR    = 6'h25,
        OP_XOR   = 6'h26,
        OP_NOR   = 6'h27,
        OP_SLT   = 6'h2a,
        OP_SLTU  = 6'h2b,
        OP_CLZ   = 6'h30,
        OP_CLO   = 6'h31
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_ARITH = 3'd3,
        RES_MOVE  = 3'd4,
        RES_MUL   = 3'd5
    } res_class_e;

    // MULT, MULTU, MTHI and MTLO only touch HI/LO
    function automatic res_class_e op_class(input alu_op_e op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        return RES_SHIFT;
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_CLZ, OP_CLO:                return RES_ARITH;
            OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN: return RES_MOVE;
            OP_MUL:                        return RES_MUL;
            default:                       return RES_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire
